// ==== hb_types_pkg.sv ====
// shared data types for the h-bridge controller: adc samples, switch commands, lead values
package hb_types_pkg;

   //------------------------------------------------------------
   // tank adc words
   //------------------------------------------------------------
   // two's complement sample, as delivered by the adc with dfs high
   typedef logic signed [13:0] adc_sample_t;

   // offset-binary code for the dac monitor outputs
   typedef logic [13:0] adc_code_t;

   //------------------------------------------------------------
   // bridge and setpoint words
   //------------------------------------------------------------
   // switch bits:
   //   [0] leg 1 high side
   //   [1] leg 2 high side
   //   [2] leg 1 low side
   //   [3] leg 2 low side
   typedef logic [3:0] bridge_cmd_t;

   // lead angle in clock cycles
   typedef logic [4:0] lead_t;

   // index into the dead-time table
   typedef logic [1:0] dt_sel_t;

endpackage

// ==== hb_params_pkg.sv ====
// converter constants for the h-bridge controller, imported by the rtl blocks that need them
package hb_params_pkg;
   import hb_types_pkg::*;

   //------------------------------------------------------------
   // adc codes
   //------------------------------------------------------------
   localparam adc_sample_t ADC_MIN_CODE = 14'h2000;  // -8192, also the over-range marker
   localparam adc_sample_t ADC_MAX_POS  = 14'h1fff;  // +8191

   // debounce
   localparam int DEBOUNCE_CYCLES = 16;                      // steady cycles before a change
   localparam int DEB_CNT_W       = $clog2(DEBOUNCE_CYCLES); // counts 0 .. 15

   // lead setpoint limits
   localparam lead_t LEAD_MAX  = 5'd31;
   localparam lead_t LEAD_STEP = 5'd1;   // per button press

   //------------------------------------------------------------
   // start-up sequence
   //------------------------------------------------------------
   localparam int BOOT_CYCLES = 10;                    // low sides on, bootstrap charge
   localparam int FORCE_END   = 16;                    // forced sigma=1 until here
   localparam int PHASE_W     = $clog2(FORCE_END + 1); // counter holds FORCE_END

   // dead time, cycles per selector value
   localparam int DT_CNT_W = 4;
   localparam logic [DT_CNT_W-1:0] DEAD_TABLE [4] = '{4'd2, 4'd4, 4'd8, 4'd12};

   //------------------------------------------------------------
   // bridge patterns
   //------------------------------------------------------------
   localparam bridge_cmd_t CMD_BOOT = 4'b1100;  // both low sides
   localparam bridge_cmd_t CMD_POS  = 4'b1001;  // leg 1 high, leg 2 low
   localparam bridge_cmd_t CMD_NEG  = 4'b0110;  // leg 2 high, leg 1 low

endpackage

// ==== adc_conditioner.sv ====
// registers one tank adc channel with over-range saturation, polarity inversion and dac copy
`timescale 1ns/1ns

module adc_conditioner
   import hb_types_pkg::*, hb_params_pkg::*;
(
   input  logic        ADA_DCO,
   input  logic        i_rst_n,
   input  adc_sample_t i_data,     // raw two's complement code
   input  logic        i_or,       // adc over-range flag
   output adc_sample_t o_sample,   // conditioned sample
   output adc_code_t   o_monitor   // offset-binary copy for the dac
);

   adc_sample_t s_next;

   // polarity is inverted on the current board, so negate
   // -8192 has no positive twin, it maps to full scale either way
   always_comb begin
      if (i_data == ADC_MIN_CODE) begin
         s_next = ADC_MAX_POS;
      end else if (i_or) begin
         s_next = ADC_MIN_CODE;   // any other over-range code pins low
      end else begin
         s_next = -i_data;
      end
   end

   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_sample  <= '0;
         o_monitor <= '0;
      end else begin
         o_sample  <= s_next;
         o_monitor <= {~s_next[13], s_next[12:0]};  // flip sign bit -> offset binary
      end
   end

   // the minimum code only comes out of an over-range sample
   a_min_only_on_or : assert property (
      @(posedge ADA_DCO) disable iff (!i_rst_n)
      (o_sample == ADC_MIN_CODE) |-> $past(i_or)
   );

endmodule

// ==== input_debounce.sv ====
// debounces the enable switch and the three buttons, one stability counter per input bit
`timescale 1ns/1ns

module input_debounce
   import hb_params_pkg::*;
(
   input  logic       ADA_DCO,
   input  logic       i_rst_n,
   input  logic [3:0] i_raw,    // bit 0 switch, bits 3:1 buttons
   output logic [3:0] o_clean
);

   logic [DEB_CNT_W-1:0] cnt [4];   // cycles the raw bit has differed

   //------------------------------------------------------------
   // per-bit stability counters
   //------------------------------------------------------------
   // a bit that disagrees with its clean value counts up
   // any agreement throws the count away
   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_clean <= '0;
         for (int b = 0; b < 4; b++) begin
            cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < 4; b++) begin
            if (i_raw[b] == o_clean[b]) begin
               cnt[b] <= '0;                          // steady, nothing pending
            end else if (cnt[b] == DEB_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
               o_clean[b] <= i_raw[b];                // held long enough, take it
               cnt[b]     <= '0;
            end else begin
               cnt[b] <= cnt[b] + 1'b1;
            end
         end
      end
   end

endmodule

// ==== lead_setpoint.sv ====
// lead angle setpoint in clock cycles that the debounced reset, up and down buttons move
`timescale 1ns/1ns

module lead_setpoint
   import hb_types_pkg::*, hb_params_pkg::*;
(
   input  logic  ADA_DCO,
   input  logic  i_rst_n,
   input  logic  i_btn_reset,   // debounced levels
   input  logic  i_btn_up,
   input  logic  i_btn_down,
   output lead_t o_lead
);

   logic [2:0] btn_prev;   // {down, up, reset} of last cycle
   logic       rise_reset, rise_up, rise_down;

   // one action per press
   assign rise_reset = i_btn_reset & ~btn_prev[0];
   assign rise_up    = i_btn_up    & ~btn_prev[1];
   assign rise_down  = i_btn_down  & ~btn_prev[2];

   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         btn_prev <= '0;
         o_lead   <= '0;
      end else begin
         btn_prev <= {i_btn_down, i_btn_up, i_btn_reset};
         // reset wins over up and up over down
         if (rise_reset) begin
            o_lead <= '0;
         end else if (rise_up) begin
            if (o_lead > LEAD_MAX - LEAD_STEP) begin
               o_lead <= LEAD_MAX;               // clamp top
            end else begin
               o_lead <= o_lead + LEAD_STEP;
            end
         end else if (rise_down) begin
            if (o_lead < LEAD_STEP) begin
               o_lead <= '0;                     // clamp bottom
            end else begin
               o_lead <= o_lead - LEAD_STEP;
            end
         end
      end
   end

   // full scale is left only by a reset or down press and never wraps
   a_lead_in_range : assert property (
      @(posedge ADA_DCO) disable iff (!i_rst_n)
      (o_lead == LEAD_MAX) && !rise_reset && !rise_down |=> (o_lead == LEAD_MAX)
   );

endmodule

// ==== current_commutator.sv ====
// switching law that makes the bridge follow the tank current sign after the lead delay
`timescale 1ns/1ns

module current_commutator
   import hb_types_pkg::*, hb_params_pkg::*;
(
   input  logic        ADA_DCO,
   input  logic        i_rst_n,
   input  adc_sample_t i_current,   // conditioned tank current
   input  lead_t       i_lead,      // flip after lead+1 cycles
   input  logic        i_run,       // supervisor in normal phase
   output bridge_cmd_t o_cmd
);

   logic  sigma;      // 1 in the positive half wave
   logic  cur_pos;    // zero counts as positive
   lead_t dis_cnt;    // cycles the sign has disagreed with sigma

   assign cur_pos = ~i_current[13];

   //------------------------------------------------------------
   // sigma update
   //------------------------------------------------------------
   // sigma flips once the sign has disagreed for lead+1 cycles
   // >= instead of == so a lead lowered mid-count still fires
   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sigma   <= 1'b0;
         dis_cnt <= '0;
      end else if (!i_run) begin
         sigma   <= 1'b0;                   // held low outside normal phase
         dis_cnt <= '0;
      end else if (cur_pos == sigma) begin
         dis_cnt <= '0;                     // back in agreement so restart
      end else if (dis_cnt >= i_lead) begin
         sigma   <= cur_pos;                // commutate
         dis_cnt <= '0;
      end else begin
         dis_cnt <= dis_cnt + 1'b1;
      end
   end

   // sigma -> leg pattern
   assign o_cmd = sigma ? CMD_POS : CMD_NEG;

   // a commutation lands on a sign that disagreed for the whole lead
   a_lead_delay : assert property (
      @(posedge ADA_DCO) disable iff (!i_rst_n)
      $past(i_run) && $changed(sigma)
         |-> (sigma == $past(cur_pos)) && ($past(dis_cnt) >= $past(i_lead))
   );

endmodule

// ==== dead_time.sv ====
// dead-time insertion: each switch turns on only after its command has been high long enough
`timescale 1ns/1ns

module dead_time
   import hb_types_pkg::*, hb_params_pkg::*;
(
   input  logic        ADA_DCO,
   input  logic        i_rst_n,
   input  bridge_cmd_t i_cmd,   // raw command from the switching law
   input  dt_sel_t     i_sel,   // dead-time table index
   output bridge_cmd_t o_cmd    // delayed command
);

   logic [DT_CNT_W-1:0] on_cnt [4];   // cycles each command bit has been high
   logic [DT_CNT_W-1:0] dt_limit;

   // the nth high sample releases the switch
   assign dt_limit = DEAD_TABLE[i_sel] - DT_CNT_W'(1);

   //------------------------------------------------------------
   // per-switch on-delay
   //------------------------------------------------------------
   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_cmd <= '0;
         for (int b = 0; b < 4; b++) begin
            on_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < 4; b++) begin
            if (!i_cmd[b]) begin
               on_cnt[b] <= '0;             // turn-off passes straight through
               o_cmd[b]  <= 1'b0;
            end else if (on_cnt[b] >= dt_limit) begin
               o_cmd[b]  <= 1'b1;           // waited out the dead time
            end else begin
               on_cnt[b] <= on_cnt[b] + 1'b1;
            end
         end
      end
   end

   // a switch never turns on the cycle after its command rose
   a_on_delayed : assert property (
      @(posedge ADA_DCO) disable iff (!i_rst_n)
      $rose(i_cmd[0]) |=> !o_cmd[0]
   );

endmodule

// ==== bridge_supervisor.sv ====
// start-up sequencing, enable gating and shoot-through guard in front of the four gate drives
`timescale 1ns/1ns

module bridge_supervisor
   import hb_types_pkg::*, hb_params_pkg::*;
(
   input  logic        ADA_DCO,
   input  logic        i_rst_n,
   input  logic        i_enable,   // debounced enable switch
   input  bridge_cmd_t i_cmd,      // dead-timed command
   output logic        o_run,      // high only in the normal phase
   output bridge_cmd_t o_q         // gate drives
);

   logic [PHASE_W-1:0] phase_cnt;   // cycles since enable up to FORCE_END
   logic               in_boot, in_force;
   bridge_cmd_t        q_sel;
   logic               shoot;

   //------------------------------------------------------------
   // phase counter
   //------------------------------------------------------------
   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         phase_cnt <= '0;
      end else if (!i_enable) begin
         phase_cnt <= '0;                            // restart the sequence on every enable
      end else if (phase_cnt != PHASE_W'(FORCE_END)) begin
         phase_cnt <= phase_cnt + 1'b1;
      end
   end

   assign in_boot  = phase_cnt < PHASE_W'(BOOT_CYCLES);
   assign in_force = phase_cnt < PHASE_W'(FORCE_END);

   // pattern for the current phase
   always_comb begin
      if (!i_enable) begin
         q_sel = '0;
      end else if (in_boot) begin
         q_sel = CMD_BOOT;    // charge bootstrap caps through the low sides
      end else if (in_force) begin
         q_sel = CMD_POS;     // kick the tank with sigma=1
      end else begin
         q_sel = i_cmd;       // normal switching
      end
   end

   // both switches of one leg means a short across the bus
   assign shoot = (q_sel[0] & q_sel[2]) | (q_sel[1] & q_sel[3]);

   //------------------------------------------------------------
   // output registers
   //------------------------------------------------------------
   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_q   <= '0;
         o_run <= 1'b0;
      end else begin
         o_q   <= shoot ? bridge_cmd_t'('0) : q_sel;
         o_run <= i_enable & ~in_force;
      end
   end

   // no phase pattern and no dead-timed command ever puts both switches of a leg on
   a_no_shoot_through : assert property (
      @(posedge ADA_DCO) disable iff (!i_rst_n)
      !shoot
   );

endmodule

// ==== hbridge_top.sv ====
// top level of the resonant-tank h-bridge controller, connects all blocks to the board pins
`timescale 1ns/1ns

module hbridge_top
   import hb_types_pkg::*;
(
   input  logic        ADA_DCO,      // adc data clock, runs everything
   input  logic        i_rst_n,
   // tank adcs
   input  adc_sample_t i_ada_data,   // channel a, capacitor voltage
   input  logic        i_ada_or,
   input  adc_sample_t i_adb_data,   // channel b, tank current
   input  logic        i_adb_or,
   // user inputs
   input  logic        i_sw,         // converter enable
   input  logic [2:0]  i_button,     // [0] lead reset, [1] up, [2] down
   input  dt_sel_t     i_dt_sel,
   // outputs
   output bridge_cmd_t o_q,          // gate drives
   output adc_code_t   o_da,         // dac monitors
   output adc_code_t   o_db,
   output lead_t       o_lead        // setpoint for the debug display
);

   adc_sample_t i_c;           // conditioned tank current
   logic [3:0]  clean;         // debounced {buttons, switch}
   logic        run;
   bridge_cmd_t cmd_raw, cmd_dt;

   //------------------------------------------------------------
   // adc capture
   //------------------------------------------------------------
   // voltage channel only feeds its monitor
   adc_conditioner i_adc_v (
      .ADA_DCO  (ADA_DCO),
      .i_rst_n  (i_rst_n),
      .i_data   (i_ada_data),
      .i_or     (i_ada_or),
      .o_sample (),
      .o_monitor(o_da)
   );

   adc_conditioner i_adc_i (
      .ADA_DCO  (ADA_DCO),
      .i_rst_n  (i_rst_n),
      .i_data   (i_adb_data),
      .i_or     (i_adb_or),
      .o_sample (i_c),
      .o_monitor(o_db)
   );

   input_debounce i_debounce (
      .ADA_DCO(ADA_DCO),
      .i_rst_n(i_rst_n),
      .i_raw  ({i_button, i_sw}),
      .o_clean(clean)
   );

   lead_setpoint i_lead (
      .ADA_DCO    (ADA_DCO),
      .i_rst_n    (i_rst_n),
      .i_btn_reset(clean[1]),
      .i_btn_up   (clean[2]),
      .i_btn_down (clean[3]),
      .o_lead     (o_lead)
   );

   //------------------------------------------------------------
   // switching path: law -> dead time -> supervisor
   //------------------------------------------------------------
   current_commutator i_commutator (
      .ADA_DCO  (ADA_DCO),
      .i_rst_n  (i_rst_n),
      .i_current(i_c),
      .i_lead   (o_lead),
      .i_run    (run),
      .o_cmd    (cmd_raw)
   );

   dead_time i_dead_time (
      .ADA_DCO(ADA_DCO),
      .i_rst_n(i_rst_n),
      .i_cmd  (cmd_raw),
      .i_sel  (i_dt_sel),
      .o_cmd  (cmd_dt)
   );

   bridge_supervisor i_supervisor (
      .ADA_DCO (ADA_DCO),
      .i_rst_n (i_rst_n),
      .i_enable(clean[0]),
      .i_cmd   (cmd_dt),
      .o_run   (run),
      .o_q     (o_q)
   );

endmodule

// ==== tb_hbridge.sv ====
// self-checking simulation top that drives the h-bridge controller against a reference model
`timescale 1ns/1ns

module tb_hbridge
   import hb_types_pkg::*, hb_params_pkg::*;
;

   localparam int CYCLE_LIMIT = 6000;   // all phases plus margin
   localparam int HOLD        = DEBOUNCE_CYCLES + 4;
   localparam int TEST_LEAD   = 3;

   logic        ADA_DCO = 1'b0;
   logic        rst_n;
   adc_sample_t ada_data, adb_data;
   logic        ada_or, adb_or, sw;
   logic [2:0]  button;
   dt_sel_t     dt_sel;
   bridge_cmd_t o_q;
   adc_code_t   o_da, o_db;
   lead_t       o_lead;

   integer seed;
   int     cycles = 0;

   always #2 ADA_DCO = ~ADA_DCO;   // 4 ns period

   hbridge_top i_hbridge_top (
      .ADA_DCO(ADA_DCO), .i_rst_n(rst_n),
      .i_ada_data(ada_data), .i_ada_or(ada_or),
      .i_adb_data(adb_data), .i_adb_or(adb_or),
      .i_sw(sw), .i_button(button), .i_dt_sel(dt_sel),
      .o_q(o_q), .o_da(o_da), .o_db(o_db), .o_lead(o_lead)
   );

   //------------------------------------------------------------
   // failure reporting
   //------------------------------------------------------------
   task automatic abort_run();
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic value_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
      $display("error at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
      abort_run();
   endtask

   task automatic report_failure(string msg);
      $display("%s at %0t ns", msg, $time);
      abort_run();
   endtask

   always @(posedge ADA_DCO) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         report_failure("run did not finish within the cycle limit");
      end
   end

   //------------------------------------------------------------
   // reference model
   //------------------------------------------------------------
   // min code saturates high, over-range pins low, the rest is negated
   function automatic adc_sample_t condition(adc_sample_t raw, logic ovr);
      if (raw == ADC_MIN_CODE) return ADC_MAX_POS;
      if (ovr) return ADC_MIN_CODE;
      return adc_sample_t'(14'd0 - raw);
   endfunction

   function automatic adc_code_t to_offset(adc_sample_t s);
      return adc_code_t'(s) ^ 14'h2000;   // offset binary = two's complement + half scale
   endfunction

   function automatic int dead_need(dt_sel_t sel);
      return int'(DEAD_TABLE[sel]) - 1;   // turn-off itself takes one cycle
   endfunction

   adc_sample_t m_sb;
   adc_code_t   m_da, m_db;
   logic [3:0]  m_clean;
   int          m_deb [4];
   logic [2:0]  m_btn_prev;
   lead_t       m_lead;
   logic        m_sigma;
   int          m_dis;
   bridge_cmd_t m_dt, m_q, m_law, m_sel;
   int          m_on [4];
   int          m_phase;
   logic        m_run;
   logic [3:0]  raw_in;

   assign raw_in = {button, sw};
   assign m_law  = m_sigma ? CMD_POS : CMD_NEG;

   always_comb begin
      if (!m_clean[0]) m_sel = '0;
      else if (m_phase < BOOT_CYCLES) m_sel = CMD_BOOT;
      else if (m_phase < FORCE_END) m_sel = CMD_POS;
      else m_sel = m_dt;
   end

   always @(posedge ADA_DCO or negedge rst_n) begin
      if (!rst_n) begin
         m_sb       <= '0;
         m_da       <= '0;
         m_db       <= '0;
         m_clean    <= '0;
         m_btn_prev <= '0;
         m_lead     <= '0;
         m_sigma    <= 1'b0;
         m_dis      <= 0;
         m_dt       <= '0;
         m_phase    <= 0;
         m_q        <= '0;
         m_run      <= 1'b0;
         for (int b = 0; b < 4; b++) begin
            m_deb[b] <= 0;
            m_on[b]  <= 0;
         end
      end else begin
         m_sb <= condition(adb_data, adb_or);
         m_da <= to_offset(condition(ada_data, ada_or));
         m_db <= to_offset(condition(adb_data, adb_or));
         for (int b = 0; b < 4; b++) begin
            if (raw_in[b] == m_clean[b]) m_deb[b] <= 0;
            else if (m_deb[b] + 1 == DEBOUNCE_CYCLES) begin
               m_clean[b] <= raw_in[b];   // steady long enough
               m_deb[b]   <= 0;
            end else m_deb[b] <= m_deb[b] + 1;
         end
         // one step per rising edge with reset over up over down
         m_btn_prev <= m_clean[3:1];
         if (m_clean[1] && !m_btn_prev[0]) m_lead <= '0;
         else if (m_clean[2] && !m_btn_prev[1])
            m_lead <= lead_t'((int'(m_lead) + 1 > int'(LEAD_MAX)) ? int'(LEAD_MAX)
                                                                 : int'(m_lead) + 1);
         else if (m_clean[3] && !m_btn_prev[2])
            m_lead <= lead_t'((int'(m_lead) == 0) ? 0 : int'(m_lead) - 1);
         // non-negative current counts as positive in the switching law
         if (!m_run) begin
            m_sigma <= 1'b0;
            m_dis   <= 0;
         end else if (!m_sb[13] == m_sigma) m_dis <= 0;
         else if (m_dis + 1 >= int'(m_lead) + 1) begin
            m_sigma <= !m_sb[13];
            m_dis   <= 0;
         end else m_dis <= m_dis + 1;
         for (int b = 0; b < 4; b++) begin
            if (!m_law[b]) begin
               m_on[b] <= 0;
               m_dt[b] <= 1'b0;
            end else if (m_on[b] + 1 >= int'(DEAD_TABLE[dt_sel])) m_dt[b] <= 1'b1;
            else m_on[b] <= m_on[b] + 1;
         end
         // supervisor phases
         if (!m_clean[0]) m_phase <= 0;
         else if (m_phase != FORCE_END) m_phase <= m_phase + 1;
         m_q   <= ((m_sel[0] && m_sel[2]) || (m_sel[1] && m_sel[3])) ? 4'b0000 : m_sel;
         m_run <= m_clean[0] && (m_phase >= FORCE_END);
      end
   end

   // leg off-time tracking for the dead-time check
   bridge_cmd_t q_prev;
   logic        run_prev;
   int          off_len [2];
   logic [1:0]  turn_on;

   assign turn_on[0] = (o_q[0] & ~q_prev[0]) | (o_q[2] & ~q_prev[2]);
   assign turn_on[1] = (o_q[1] & ~q_prev[1]) | (o_q[3] & ~q_prev[3]);

   always @(posedge ADA_DCO or negedge rst_n) begin
      if (!rst_n) begin
         q_prev     <= '0;
         run_prev   <= 1'b0;
         off_len[0] <= 0;
         off_len[1] <= 0;
      end else begin
         q_prev   <= o_q;
         run_prev <= m_run;
         for (int l = 0; l < 2; l++) begin
            off_len[l] <= (!o_q[l] && !o_q[l+2]) ? off_len[l] + 1 : 0;
         end
      end
   end

   //------------------------------------------------------------
   // checks
   //------------------------------------------------------------
   a_q : assert property (@(posedge ADA_DCO) disable iff (!rst_n) o_q == m_q)
      else value_mismatch("o_q", 32'($sampled(m_q)), 32'($sampled(o_q)));
   a_da : assert property (@(posedge ADA_DCO) disable iff (!rst_n) o_da == m_da)
      else value_mismatch("o_da", 32'($sampled(m_da)), 32'($sampled(o_da)));
   a_db : assert property (@(posedge ADA_DCO) disable iff (!rst_n) o_db == m_db)
      else value_mismatch("o_db", 32'($sampled(m_db)), 32'($sampled(o_db)));
   a_lead : assert property (@(posedge ADA_DCO) disable iff (!rst_n) o_lead == m_lead)
      else value_mismatch("o_lead", 32'($sampled(m_lead)), 32'($sampled(o_lead)));
   a_no_short : assert property (@(posedge ADA_DCO) disable iff (!rst_n)
      !((o_q[0] && o_q[2]) || (o_q[1] && o_q[3])))
      else report_failure("both switches of one leg are on");
   a_dead_leg1 : assert property (@(posedge ADA_DCO) disable iff (!rst_n)
      (turn_on[0] && run_prev && m_run) |-> off_len[0] >= dead_need(dt_sel))
      else report_failure("leg 1 switched on before the dead time ran out");
   a_dead_leg2 : assert property (@(posedge ADA_DCO) disable iff (!rst_n)
      (turn_on[1] && run_prev && m_run) |-> off_len[1] >= dead_need(dt_sel))
      else report_failure("leg 2 switched on before the dead time ran out");

   //------------------------------------------------------------
   // stimulus
   //------------------------------------------------------------
   task automatic step(int n);
      repeat (n) @(posedge ADA_DCO);
      #1;   // inputs change just after the edge
   endtask

   task automatic press(logic [2:0] which);
      button = which;
      step(HOLD);
      button = '0;
      step(HOLD);
   endtask

   task automatic sweep_adc_codes();
      logic [31:0] r;
      for (int i = 0; i < 200; i++) begin
         r        = $random(seed);
         ada_data = r[13:0];
         ada_or   = (r[20:18] == 3'd0);
         adb_data = r[27:14];
         adb_or   = (r[31:29] == 3'd0);
         if (i % 8 == 1 || i % 8 == 5) begin
            adb_data = ADC_MIN_CODE;      // saturates high with or without over-range
            adb_or   = (i % 8 == 1);
            ada_data = ADC_MIN_CODE;
         end else if (i % 8 == 3) begin
            adb_or = 1'b1;                // other code over range
            ada_or = 1'b1;
         end
         step(1);
      end
      ada_or   = 1'b0;
      adb_or   = 1'b0;
      adb_data = '0;
   endtask

   task automatic exercise_lead_buttons();
      repeat (3) press(3'b010);
      press(3'b011);                      // reset and up together so reset wins
      repeat (5) press(3'b100);           // clamps at zero
      press(3'b110);                      // up and down together so up wins
      repeat (33) press(3'b010);          // clamps at the top
      press(3'b001);
      repeat (TEST_LEAD) press(3'b010);
   endtask

   // one enable cycle with held current signs and short glitches
   task automatic commutation_cycle(dt_sel_t sel);
      logic [31:0] r;
      logic        neg;
      sw     = 1'b0;
      dt_sel = sel;
      step(30);
      sw = 1'b1;
      step(DEBOUNCE_CYCLES + FORCE_END + 4);
      for (int k = 0; k < 8; k++) begin
         neg = k[0];
         for (int c = 0; c < 40; c++) begin
            r        = $random(seed);
            adb_data = {neg, r[12:0]};
            step(1);
         end
         for (int c = 0; c < TEST_LEAD - 1; c++) begin
            r        = $random(seed);
            adb_data = {~neg, r[12:0]};   // shorter than lead+1 so no commutation
            step(1);
         end
      end
      sw = 1'b0;
      step(30);
   endtask

   initial begin
      seed     = 32'h39a1dfe5;
      rst_n    = 1'b0;
      ada_data = '0;
      ada_or   = 1'b0;
      adb_data = '0;
      adb_or   = 1'b0;
      sw       = 1'b0;
      button   = '0;
      dt_sel   = '0;
      repeat (16) @(posedge ADA_DCO);
      #1 rst_n = 1'b1;
      sweep_adc_codes();
      exercise_lead_buttons();
      for (int s = 0; s < 4; s++) begin
         commutation_cycle(dt_sel_t'(s));
      end
      $display("All tests passed");
      $finish;
   end

endmodule

// ==== all.f ====
hb_types_pkg.sv
hb_params_pkg.sv
adc_conditioner.sv
input_debounce.sv
lead_setpoint.sv
current_commutator.sv
dead_time.sv
bridge_supervisor.sv
hbridge_top.sv
tb_hbridge.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_hbridge -f all.f -o sim_hbridge

out=$(./obj_dir/sim_hbridge 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
   exit 0
else
   exit 1
fi
